/* src/mailbox_settings.svh */
`ifndef MAILBOX_SETTINGS_SVH
`define MAILBOX_SETTINGS_SVH

// Number of mailbox slots, must be a power of two
`define SlotCnt 8

// Width of one mail word
`define DataWidth 16

// Bits needed to number a slot
`define SlotIdxWidth $clog2(`SlotCnt)

`endif

/* src/writePkg.sv */
`default_nettype none

`include "mailbox_settings.svh"

package writePkg;

  // Slot number as carried by the producer
  typedef logic [`SlotIdxWidth-1:0] slotIdxT;

  // One mail word
  typedef logic [`DataWidth-1:0] mailDataT;

  // Producer request, strobe is high for one cycle per word
  typedef struct packed
  {
    logic     strobe;
    slotIdxT  slot;
    mailDataT data;
  } writeReqT;

endpackage

`default_nettype wire

/* src/grantPkg.sv */
`default_nettype none

`include "mailbox_settings.svh"

package grantPkg;

  import writePkg::*;

  // One bit per slot
  typedef logic [`SlotCnt-1:0] slotMaskT;

  // What a slot hands to the arbiter
  typedef struct packed
  {
    logic     pending;
    mailDataT data;
  } slotEntryT;

  // Drained word, valid is a one-cycle strobe
  typedef struct packed
  {
    logic     valid;
    slotIdxT  slot;
    mailDataT data;
  } grantT;

endpackage

`default_nettype wire

/* src/writeDecoder.sv */
`default_nettype none

`include "mailbox_settings.svh"

module writeDecoder
  import writePkg::*;
  import grantPkg::*;
(
  input  writeReqT writeReq,
  output slotMaskT writeMask
);

  // Doubling decode from the index LSB upward.
  // Each level splits every live bit into a lower and an upper half
  // depending on one more index bit
  always_comb
  begin
    writeMask = '0;
    writeMask[0] = writeReq.strobe;
    for (int lvl = 0; lvl < `SlotIdxWidth; lvl++)
    begin
      for (int i = 0; i < (1 << lvl); i++)
      begin
        // Upper copy first, it reads the bit the lower copy overwrites
        writeMask[i + (1 << lvl)] = writeMask[i] & writeReq.slot[lvl];
        writeMask[i] = writeMask[i] & ~writeReq.slot[lvl];
      end
    end
  end

endmodule

`default_nettype wire

/* src/mailSlot.sv */
`default_nettype none

module mailSlot
  import writePkg::*;
  import grantPkg::*;
(
  input  logic      AClkB,
  input  logic      AResetBN,
  input  logic      writeEn,
  input  mailDataT  writeData,
  input  logic      grantEn,
  output slotEntryT entry
);

  logic     pendingReg;
  mailDataT dataReg;

  // A new write wins over a grant at the same edge,
  // so the slot stays pending with the fresh word
  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (AResetBN == 1'b0)
    begin
      pendingReg <= 1'b0;
    end
    else if (writeEn)
    begin
      pendingReg <= 1'b1;
    end
    else if (grantEn)
    begin
      pendingReg <= 1'b0;
    end
  end

  // Overwrite of a pending word simply replaces it
  always_ff @(posedge AClkB)
  begin
    if (writeEn)
    begin
      dataReg <= writeData;
    end
  end

  assign entry.pending = pendingReg;
  assign entry.data = dataReg;

endmodule

`default_nettype wire

/* src/roundRobinArbiter.sv */
`default_nettype none

`include "mailbox_settings.svh"

module roundRobinArbiter
  import writePkg::*;
  import grantPkg::*;
(
  input  logic      AClkB,
  input  logic      AResetBN,
  input  logic      drainEn,
  input  slotEntryT entries [`SlotCnt],
  output slotMaskT  grantMask,
  output grantT     grant
);

  // One-hot pointer to the slot with highest priority
  slotMaskT ptrReg;
  slotMaskT nextPtr;

  slotMaskT pendVec;
  slotMaskT rotPending;
  slotMaskT pickMask;
  slotMaskT winMask;

  logic [2*`SlotCnt-1:0] pendTwice;
  logic [2*`SlotCnt-1:0] pickTwice;

  logic     grantFire;
  slotIdxT  grantIdx;
  mailDataT grantData;

  always_comb
  begin
    for (int i = 0; i < `SlotCnt; i++)
    begin
      pendVec[i] = entries[i].pending;
    end
  end

  assign pendTwice = {pendVec, pendVec};

  // Rotate right so the pointer slot lands on bit 0.
  // Row k of the rotation matrix is taken when the pointer is at k
  always_comb
  begin
    rotPending = '0;
    for (int row = 0; row < `SlotCnt; row++)
    begin
      for (int col = 0; col < `SlotCnt; col++)
      begin
        rotPending[col] = rotPending[col] | (pendTwice[row + col] & ptrReg[row]);
      end
    end
  end

  // Keep only the lowest request after rotation
  always_comb
  begin
    logic seen;
    seen = 1'b0;
    for (int j = 0; j < `SlotCnt; j++)
    begin
      pickMask[j] = rotPending[j] & ~seen;
      seen = seen | rotPending[j];
    end
  end

  assign pickTwice = {pickMask, pickMask};

  // Rotate back to real slot positions
  always_comb
  begin
    winMask = '0;
    for (int row = 0; row < `SlotCnt; row++)
    begin
      for (int col = 0; col < `SlotCnt; col++)
      begin
        winMask[col] = winMask[col] | (pickTwice[`SlotCnt - row + col] & ptrReg[row]);
      end
    end
  end

  // No grant at all while draining is held off
  assign grantMask = winMask & {`SlotCnt{drainEn}};
  assign grantFire = |grantMask;

  // Index of the one-hot winner with each bit an OR over matching slots
  always_comb
  begin
    grantIdx = '0;
    for (int i = 0; i < `SlotCnt; i++)
    begin
      for (int b = 0; b < `SlotIdxWidth; b++)
      begin
        if (((i >> b) & 1) != 0)
        begin
          grantIdx[b] = grantIdx[b] | grantMask[i];
        end
      end
    end
  end

  // AND-OR row select of the winner's word
  always_comb
  begin
    grantData = '0;
    for (int i = 0; i < `SlotCnt; i++)
    begin
      grantData = grantData | (entries[i].data & {`DataWidth{grantMask[i]}});
    end
  end

  // Winner moved up by one with the top slot wrapping to slot 0
  assign nextPtr = {grantMask[`SlotCnt-2:0], grantMask[`SlotCnt-1]};

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (AResetBN == 1'b0)
    begin
      ptrReg <= slotMaskT'(1);
    end
    else if (grantFire)
    begin
      ptrReg <= nextPtr;
    end
  end

  // Grant leaves one edge after the entries it was picked from
  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (AResetBN == 1'b0)
    begin
      grant <= '0;
    end
    else
    begin
      grant.valid <= grantFire;
      grant.slot <= grantIdx;
      grant.data <= grantData;
    end
  end

endmodule

`default_nettype wire

/* src/mailboxTop.sv */
`default_nettype none

`include "mailbox_settings.svh"

module mailboxTop
  import writePkg::*;
  import grantPkg::*;
(
  input  logic     AClkB,
  input  logic     AResetBN,
  input  writeReqT writeReq,
  input  logic     drainEn,
  output grantT    grant,
  output slotMaskT pending
);

  slotMaskT  writeMask;
  slotMaskT  grantMask;
  slotEntryT entries [`SlotCnt];

  writeDecoder decoder_i
  (
    .writeReq  (writeReq),
    .writeMask (writeMask)
  );

  // All slots see the same write word, only the masked one loads it
  for (genvar i = 0; i < `SlotCnt; i++)
  begin : gSlot
    mailSlot slot_i
    (
      .AClkB     (AClkB),
      .AResetBN  (AResetBN),
      .writeEn   (writeMask[i]),
      .writeData (writeReq.data),
      .grantEn   (grantMask[i]),
      .entry     (entries[i])
    );

    assign pending[i] = entries[i].pending;
  end

  roundRobinArbiter arbiter_i
  (
    .AClkB     (AClkB),
    .AResetBN  (AResetBN),
    .drainEn   (drainEn),
    .entries   (entries),
    .grantMask (grantMask),
    .grant     (grant)
  );

endmodule

`default_nettype wire

/* sim/mailboxTb.sv */
`default_nettype none

`include "mailbox_settings.svh"

module mailboxTb
  import writePkg::*;
  import grantPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 8;
  localparam int randCycles = 200;

  // One table row with the inputs of a cycle and the outputs seen in it
  typedef struct packed
  {
    writeReqT req;
    logic     drain;
    grantT    expGrant;
    slotMaskT expPending;
  } stepT;

  logic     AClkB;
  logic     AResetBN;
  writeReqT writeReq;
  logic     drainEn;
  grantT    grant;
  slotMaskT pending;

  stepT steps [$];
  logic tableReady;

  // Behavioural mailbox state
  slotMaskT modelPend;
  mailDataT modelData [`SlotCnt];
  int       modelPtr;
  grantT    modelGrant;

  mailboxTop dut_i
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .writeReq (writeReq),
    .drainEn  (drainEn),
    .grant    (grant),
    .pending  (pending)
  );

  initial
  begin
    AClkB = 1'b0;
    forever #(clkPeriod / 2) AClkB = ~AClkB;
  end

  function automatic stepT makeStep(input logic strobe, input int slot, input mailDataT data,
                                    input logic drain, input logic expValid, input int expSlot,
                                    input mailDataT expData, input slotMaskT expPending);
    stepT s;
    s.req.strobe = strobe;
    s.req.slot = slotIdxT'(slot);
    s.req.data = data;
    s.drain = drain;
    s.expGrant.valid = expValid;
    s.expGrant.slot = slotIdxT'(expSlot);
    s.expGrant.data = expData;
    s.expPending = expPending;
    return s;
  endfunction

  task automatic buildTable();
    // Idle after reset
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'h00));
    // Fill 5, 2 and 7 while held with the pointer still at slot 0
    steps.push_back(makeStep(1'b1, 5, 16'h0505, 1'b0, 1'b0, 0, 16'h0000, 8'h00));
    steps.push_back(makeStep(1'b1, 2, 16'h0202, 1'b0, 1'b0, 0, 16'h0000, 8'h20));
    steps.push_back(makeStep(1'b1, 7, 16'h0707, 1'b0, 1'b0, 0, 16'h0000, 8'h24));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'hA4));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 2, 16'h0202, 8'hA0));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 5, 16'h0505, 8'h80));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 7, 16'h0707, 8'h00));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b0, 1'b0, 0, 16'h0000, 8'h00));
    // Pointer wrapped to 0 so 1 goes before 6 and the refilled 7
    steps.push_back(makeStep(1'b1, 6, 16'h0606, 1'b0, 1'b0, 0, 16'h0000, 8'h00));
    steps.push_back(makeStep(1'b1, 1, 16'h0101, 1'b0, 1'b0, 0, 16'h0000, 8'h40));
    steps.push_back(makeStep(1'b1, 7, 16'h7777, 1'b0, 1'b0, 0, 16'h0000, 8'h42));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'hC2));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 1, 16'h0101, 8'hC0));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 6, 16'h0606, 8'h80));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 7, 16'h7777, 8'h00));
    // Single write granted one cycle after pending shows
    steps.push_back(makeStep(1'b1, 3, 16'h1234, 1'b1, 1'b0, 0, 16'h0000, 8'h00));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'h08));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 3, 16'h1234, 8'h00));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'h00));
    // Two writes to one slot while held leave only the last word to drain
    steps.push_back(makeStep(1'b1, 1, 16'hAAAA, 1'b0, 1'b0, 0, 16'h0000, 8'h00));
    steps.push_back(makeStep(1'b1, 1, 16'hBBBB, 1'b0, 1'b0, 0, 16'h0000, 8'h02));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'h02));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 1, 16'hBBBB, 8'h00));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b0, 0, 16'h0000, 8'h00));
    // Rewrite slot 4 on the edge that grants it
    steps.push_back(makeStep(1'b1, 4, 16'h4444, 1'b0, 1'b0, 0, 16'h0000, 8'h00));
    steps.push_back(makeStep(1'b1, 4, 16'h5555, 1'b1, 1'b0, 0, 16'h0000, 8'h10));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 4, 16'h4444, 8'h10));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b1, 1'b1, 4, 16'h5555, 8'h00));
    steps.push_back(makeStep(1'b0, 0, 16'h0000, 1'b0, 1'b0, 0, 16'h0000, 8'h00));
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Run aborted");
  endtask

  // Slot and data only matter when a grant is expected
  task automatic checkGrant(input grantT actual, input grantT expected, input int step);
    logic bad;
    if (expected.valid)
    begin
      bad = (actual !== expected);
    end
    else
    begin
      bad = (actual.valid !== 1'b0);
    end
    if (bad)
    begin
      abortRun($sformatf("mismatch grant at step %0d: got %h, expected %h",
                         step, actual, expected));
    end
  endtask

  task automatic checkPending(input slotMaskT actual, input slotMaskT expected, input int step);
    if (actual !== expected)
    begin
      abortRun($sformatf("mismatch pending at step %0d: got %h, expected %h",
                         step, actual, expected));
    end
  endtask

  // Applies one cycle of inputs as the sampling edge would
  task automatic advanceModel(input writeReqT req, input logic drain);
    int win;
    int k;
    win = -1;
    if (drain)
    begin
      for (int n = 0; n < `SlotCnt; n++)
      begin
        k = (modelPtr + n) % `SlotCnt;
        if (win < 0 && modelPend[k])
        begin
          win = k;
        end
      end
    end
    modelGrant = '0;
    if (win >= 0)
    begin
      modelGrant.valid = 1'b1;
      modelGrant.slot = slotIdxT'(win);
      modelGrant.data = modelData[win];
      modelPend[win] = 1'b0;
      modelPtr = (win + 1) % `SlotCnt;
    end
    // Write lands after the grant picked the old word
    if (req.strobe)
    begin
      modelPend[req.slot] = 1'b1;
      modelData[req.slot] = req.data;
    end
  endtask

  initial
  begin
    int unsigned seedVal;
    writeReqT    req;
    logic        drain;
    AResetBN = 1'b0;
    writeReq = '0;
    drainEn = 1'b0;
    tableReady = 1'b0;
    seedVal = $urandom(79);
    buildTable();
    tableReady = 1'b1;
    modelPend = '0;
    modelPtr = 0;
    modelGrant = '0;
    repeat (2) @(posedge AClkB);
    AResetBN <= 1'b1;

    for (int i = 0; i < steps.size(); i++)
    begin
      @(posedge AClkB);
      writeReq <= steps[i].req;
      drainEn <= steps[i].drain;
      @(negedge AClkB);
      checkGrant(grant, steps[i].expGrant, i);
      checkPending(pending, steps[i].expPending, i);
      advanceModel(steps[i].req, steps[i].drain);
    end

    // Random traffic against the model
    for (int i = 0; i < randCycles; i++)
    begin
      req.strobe = 1'($urandom % 2);
      req.slot = slotIdxT'($urandom % `SlotCnt);
      req.data = mailDataT'($urandom);
      drain = (($urandom % 4) != 0);
      @(posedge AClkB);
      writeReq <= req;
      drainEn <= drain;
      @(negedge AClkB);
      checkGrant(grant, modelGrant, steps.size() + i);
      checkPending(pending, modelPend, steps.size() + i);
      advanceModel(req, drain);
    end

    $display("Test passed");
    $finish;
  end

  initial
  begin
    wait (tableReady === 1'b1);
    #((steps.size() + randCycles) * 4 * clkPeriod);
    abortRun("Run timed out before all steps completed");
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/writePkg.sv
src/grantPkg.sv
src/writeDecoder.sv
src/mailSlot.sv
src/roundRobinArbiter.sv
src/mailboxTop.sv
sim/mailboxTb.sv

/* Bender.yml */
package:
  name: mailbox

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/writePkg.sv
      - src/grantPkg.sv
      - src/writeDecoder.sv
      - src/mailSlot.sv
      - src/roundRobinArbiter.sv
      - src/mailboxTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/mailboxTb.sv
